// File: design/frv_pkg.sv
// --------------------
// Shared widths, CSR addresses, opcodes and stage payloads
// for the three-stage integer pipeline
// --------------------
package frv_pkg;

    localparam int XLEN       = 32;           // Data word width
    localparam int XL         = XLEN - 1;     // Top bit index
    localparam int REG_ADDR_W = 5;            // GPR address width
    localparam int CSR_ADDR_W = 12;           // CSR address width

    // --------------------
    // CSR map
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340; // Scratch, read/write
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hB02; // Retired count, read only

    // --------------------
    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011; // R-type ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // I-type ALU
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // CSR access

    typedef enum logic [2:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLT,                              // Signed compare
        UOP_CSRRW                             // Swap with a CSR
    } uop_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;            // Destination register
        logic [XL:0]           opr_a;         // rs1 value
        logic [XL:0]           opr_b;         // rs2 value or immediate
        uop_t                  uop;           // Micro-op
        logic [CSR_ADDR_W-1:0] csr_addr;      // CSR for CSRRW
        logic [31:0]           instr;         // Instruction word for trace
    } decode_pkt_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;            // Destination register
        logic [XL:0]           result;        // ALU result, rs1 for CSRRW
        logic                  is_csr;        // Result comes from the CSR file
        logic [CSR_ADDR_W-1:0] csr_addr;      // CSR to access in writeback
        logic [31:0]           instr;         // Instruction word for trace
    } exec_pkt_t;

endpackage

// File: design/frv_gprs.sv
// --------------------
// General purpose register file, 32 words
// Two asynchronous reads, one write, x0 reads zero
// --------------------
`timescale 1ns/1ps

module frv_gprs import frv_pkg::*; (
    input  logic                  g_clk,      // Global clock
    input  logic                  rst,        // Sync reset, active high
    input  logic [REG_ADDR_W-1:0] rs1_addr,   // Source 1 address
    input  logic [REG_ADDR_W-1:0] rs2_addr,   // Source 2 address
    output logic [XL:0]           rs1_rdata,  // Source 1 data
    output logic [XL:0]           rs2_rdata,  // Source 2 data
    input  logic                  rd_wen,     // Destination write enable
    input  logic [REG_ADDR_W-1:0] rd_addr,    // Destination address
    input  logic [XL:0]           rd_wdata    // Destination data
);

    logic [XL:0] regs [0:31];                 // Entry 0 is never written

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 hardwired
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (rd_wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_wdata;        // Lands at end of writeback
        end
    end

    // Writeback already filters rd 0 before it gets here
    a_no_x0_write : assert property (
        @(posedge g_clk) disable iff (rst) rd_wen |-> (rd_addr != '0)
    ) else $error("GPR write enable raised toward x0");

endmodule

// File: design/frv_stage_reg.sv
// --------------------
// Pipeline stage register
// Valid bit with reset, payload of any packed type
// --------------------
`timescale 1ns/1ps

module frv_stage_reg #(
    parameter type payload_t = logic          // Stage payload
) (
    input  logic     g_clk,                   // Global clock
    input  logic     rst,                     // Sync reset, active high
    input  logic     in_valid,                // Upstream stage valid
    input  payload_t in_data,                 // Upstream payload
    output logic     out_valid,               // Registered valid
    output payload_t out_data                 // Registered payload
);

    always_ff @(posedge g_clk) begin
        if (rst) begin
            out_valid <= 1'b0;                // Pipeline empty after reset
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        out_data <= in_data;                  // Captured on every edge
    end

    a_empty_after_reset : assert property (
        @(posedge g_clk) rst |=> !out_valid
    ) else $error("Stage valid set in the cycle after reset");

endmodule

// File: design/frv_forward.sv
// --------------------
// Operand forwarding and hazard detection for decode
// Youngest match wins, CSR result in execute causes a bubble
// --------------------
`timescale 1ns/1ps

module frv_forward import frv_pkg::*; (
    input  logic                  g_clk,         // Global clock
    input  logic                  rst,           // Sync reset, active high
    input  logic [REG_ADDR_W-1:0] rs1_addr,      // Decode source 1
    input  logic [REG_ADDR_W-1:0] rs2_addr,      // Decode source 2
    input  logic                  rs1_used,      // Source 1 read by instruction
    input  logic                  rs2_used,      // Source 2 read by instruction
    input  logic [XL:0]           gpr_rs1_rdata, // Register file data 1
    input  logic [XL:0]           gpr_rs2_rdata, // Register file data 2
    input  logic                  fwd_s2_valid,  // Execute holds an instruction
    input  logic [REG_ADDR_W-1:0] fwd_s2_rd,     // Execute destination
    input  logic [XL:0]           fwd_s2_wdata,  // Execute result
    input  logic                  fwd_s2_csr,    // Execute holds a CSRRW
    input  logic                  fwd_s3_valid,  // Writeback holds an instruction
    input  logic [REG_ADDR_W-1:0] fwd_s3_rd,     // Writeback destination
    input  logic [XL:0]           fwd_s3_wdata,  // Writeback data
    output logic [XL:0]           fwd_rs1_rdata, // Forwarded source 1
    output logic [XL:0]           fwd_rs2_rdata, // Forwarded source 2
    output logic                  bubble         // Hold decode one cycle
);

    // --------------------
    // Hazard matches, non-zero sources only
    logic hzd_rs1_s2;
    logic hzd_rs1_s3;
    logic hzd_rs2_s2;
    logic hzd_rs2_s3;

    assign hzd_rs1_s2 = rs1_used && (rs1_addr != '0) && fwd_s2_valid && (rs1_addr == fwd_s2_rd);
    assign hzd_rs1_s3 = rs1_used && (rs1_addr != '0) && fwd_s3_valid && (rs1_addr == fwd_s3_rd);
    assign hzd_rs2_s2 = rs2_used && (rs2_addr != '0) && fwd_s2_valid && (rs2_addr == fwd_s2_rd);
    assign hzd_rs2_s3 = rs2_used && (rs2_addr != '0) && fwd_s3_valid && (rs2_addr == fwd_s3_rd);

    // CSR data only exists in writeback
    assign bubble = fwd_s2_csr && (hzd_rs1_s2 || hzd_rs2_s2);

    // --------------------
    // Operand select, execute first
    assign fwd_rs1_rdata = hzd_rs1_s2 ? fwd_s2_wdata :
                           hzd_rs1_s3 ? fwd_s3_wdata : gpr_rs1_rdata;
    assign fwd_rs2_rdata = hzd_rs2_s2 ? fwd_s2_wdata :
                           hzd_rs2_s3 ? fwd_s3_wdata : gpr_rs2_rdata;

    // CSRRW moves on to writeback, so the stall never repeats
    a_bubble_one_cycle : assert property (
        @(posedge g_clk) disable iff (rst)
        bubble |-> (fwd_s2_valid && fwd_s2_csr) ##1 !bubble
    ) else $error("Bubble without CSR in execute or longer than one cycle");

endmodule

// File: design/frv_decode.sv
// --------------------
// Decode stage
// R-type, ADDI and CSRRW into the execute payload
// --------------------
`timescale 1ns/1ps

module frv_decode import frv_pkg::*; (
    input  logic                  instr_valid,   // Instruction present
    input  logic [XL:0]           instr_data,    // Instruction word
    input  logic                  bubble,        // Stall from hazard unit
    input  logic [XL:0]           fwd_rs1_rdata, // Forwarded source 1
    input  logic [XL:0]           fwd_rs2_rdata, // Forwarded source 2
    output logic [REG_ADDR_W-1:0] rs1_addr,      // Source 1 address
    output logic [REG_ADDR_W-1:0] rs2_addr,      // Source 2 address
    output logic                  rs1_used,      // Source 1 is read
    output logic                  rs2_used,      // Source 2 is read
    output logic                  s2_valid,      // Payload valid into execute
    output decode_pkt_t           s2_data        // Execute payload
);

    logic [6:0]  dec_opcode;
    logic [2:0]  dec_funct3;
    logic [6:0]  dec_funct7;
    logic [XL:0] dec_imm;                        // I-type immediate
    logic        is_rtype;                       // Known funct7/funct3 pair
    uop_t        rtype_uop;
    logic        dec_op;
    logic        dec_addi;
    logic        dec_csrrw;
    logic        dec_any;                        // In the supported subset

    // --------------------
    // Field extraction
    assign dec_opcode = instr_data[6:0];
    assign dec_funct3 = instr_data[14:12];
    assign dec_funct7 = instr_data[31:25];
    assign rs1_addr   = instr_data[19:15];
    assign rs2_addr   = instr_data[24:20];
    assign dec_imm    = {{(XLEN-12){instr_data[XL]}}, instr_data[XL:20]}; // Sign extend

    always_comb begin
        is_rtype  = 1'b1;
        rtype_uop = UOP_ADD;
        case ({dec_funct7, dec_funct3})
            {7'h00, 3'b000}: rtype_uop = UOP_ADD;
            {7'h20, 3'b000}: rtype_uop = UOP_SUB;
            {7'h00, 3'b111}: rtype_uop = UOP_AND;
            {7'h00, 3'b110}: rtype_uop = UOP_OR;
            {7'h00, 3'b100}: rtype_uop = UOP_XOR;
            {7'h00, 3'b010}: rtype_uop = UOP_SLT;
            default:         is_rtype  = 1'b0;   // Outside subset
        endcase
    end

    assign dec_op    = (dec_opcode == OPC_OP) && is_rtype;
    assign dec_addi  = (dec_opcode == OPC_OP_IMM) && (dec_funct3 == 3'b000);
    assign dec_csrrw = (dec_opcode == OPC_SYSTEM) && (dec_funct3 == 3'b001);
    assign dec_any   = dec_op || dec_addi || dec_csrrw;

    // Used flags also carry valid, so no stall on an idle input
    assign rs1_used = instr_valid && dec_any;
    assign rs2_used = instr_valid && dec_op;

    assign s2_valid = instr_valid && !bubble;    // Empty slot while stalled

    // --------------------
    // Payload build
    always_comb begin
        s2_data          = '0;                   // Unknown words become a no-op
        s2_data.instr    = instr_data;
        s2_data.csr_addr = instr_data[31:20];
        s2_data.uop      = dec_op    ? rtype_uop :
                           dec_csrrw ? UOP_CSRRW : UOP_ADD;
        if (dec_any) begin
            s2_data.rd    = instr_data[11:7];
            s2_data.opr_a = fwd_rs1_rdata;
        end
        if (dec_op) begin
            s2_data.opr_b = fwd_rs2_rdata;
        end else if (dec_addi) begin
            s2_data.opr_b = dec_imm;
        end
    end

endmodule

// File: design/frv_execute.sv
// --------------------
// Execute stage ALU
// Builds the writeback payload and execute forwarding values
// --------------------
`timescale 1ns/1ps

module frv_execute import frv_pkg::*; (
    input  logic                  s2_valid,      // Execute payload valid
    input  decode_pkt_t           s2_data,       // Execute payload
    output exec_pkt_t             s3_data,       // Writeback payload
    output logic                  fwd_s2_valid,  // Forwarding valid
    output logic [REG_ADDR_W-1:0] fwd_s2_rd,     // Forwarding destination
    output logic [XL:0]           fwd_s2_wdata,  // Forwarding data
    output logic                  fwd_s2_csr     // Result not known yet
);

    logic [XL:0] alu_result;
    logic        slt_lt;                         // Signed less than
    logic        is_csr;

    assign slt_lt = $signed(s2_data.opr_a) < $signed(s2_data.opr_b);
    assign is_csr = (s2_data.uop == UOP_CSRRW);

    always_comb begin
        case (s2_data.uop)
            UOP_ADD: alu_result = s2_data.opr_a + s2_data.opr_b;
            UOP_SUB: alu_result = s2_data.opr_a - s2_data.opr_b;
            UOP_AND: alu_result = s2_data.opr_a & s2_data.opr_b;
            UOP_OR:  alu_result = s2_data.opr_a | s2_data.opr_b;
            UOP_XOR: alu_result = s2_data.opr_a ^ s2_data.opr_b;
            UOP_SLT: alu_result = {{XL{1'b0}}, slt_lt};
            default: alu_result = s2_data.opr_a; // CSRRW carries rs1 as write data
        endcase
    end

    always_comb begin
        s3_data.rd       = s2_data.rd;
        s3_data.result   = alu_result;
        s3_data.is_csr   = is_csr;
        s3_data.csr_addr = s2_data.csr_addr;
        s3_data.instr    = s2_data.instr;
    end

    assign fwd_s2_valid = s2_valid;
    assign fwd_s2_rd    = s2_data.rd;
    assign fwd_s2_wdata = alu_result;            // Wrong for CSRRW, bubble covers it
    assign fwd_s2_csr   = is_csr;

endmodule

// File: design/frv_csrs.sv
// --------------------
// CSR file with mscratch and minstret
// Combinational read, update at the end of writeback
// --------------------
`timescale 1ns/1ps

module frv_csrs import frv_pkg::*; (
    input  logic                  g_clk,      // Global clock
    input  logic                  rst,        // Sync reset, active high
    input  logic                  csr_en,     // CSRRW in writeback
    input  logic [CSR_ADDR_W-1:0] csr_addr,   // CSR address
    input  logic [XL:0]           csr_wdata,  // New value
    output logic [XL:0]           csr_rdata,  // Old value
    input  logic                  instr_ret   // One instruction retired
);

    logic [XL:0] mscratch;
    logic [XL:0] minstret;

    always_comb begin
        case (csr_addr)
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MINSTRET: csr_rdata = minstret;
            default:      csr_rdata = '0;     // Unmapped reads zero
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (rst) begin
            mscratch <= '0;
        end else if (csr_en && (csr_addr == CSR_MSCRATCH)) begin
            mscratch <= csr_wdata;            // Same edge as the old value read
        end
    end

    // Writes to minstret are dropped
    always_ff @(posedge g_clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (instr_ret) begin
            minstret <= minstret + 1'b1;
        end
    end

    a_minstret_step : assert property (
        @(posedge g_clk) disable iff (rst)
        1'b1 |=> ((minstret - $past(minstret)) <= 1)
    ) else $error("minstret advanced by more than one");

endmodule

// File: design/frv_pipeline.sv
// --------------------
// Top of the three-stage integer pipeline
// Decode with forwarding, execute, then writeback to GPRs and CSRs
// --------------------
`timescale 1ns/1ps

module frv_pipeline import frv_pkg::*; (
    input  logic                  g_clk,       // Global clock
    input  logic                  rst,         // Sync reset, active high
    input  logic                  instr_valid, // Instruction offered
    input  logic [XL:0]           instr_data,  // Instruction word
    output logic                  instr_busy,  // Hold the current word
    output logic                  trs_valid,   // Trace valid
    output logic [31:0]           trs_instr,   // Trace instruction
    output logic [REG_ADDR_W-1:0] trs_rd,      // Trace destination
    output logic [XL:0]           trs_wdata,   // Trace write data
    output logic                  instr_ret    // Instruction retired
);

    logic [REG_ADDR_W-1:0] s1_rs1_addr;
    logic [REG_ADDR_W-1:0] s1_rs2_addr;
    logic                  s1_rs1_used;
    logic                  s1_rs2_used;
    logic [XL:0]           s1_rs1_rdata;       // Raw register file data
    logic [XL:0]           s1_rs2_rdata;
    logic [XL:0]           fwd_rs1_rdata;      // After forwarding
    logic [XL:0]           fwd_rs2_rdata;
    logic                  s1_bubble;

    logic                  s1_out_valid;       // Decode result into s2
    decode_pkt_t           s1_out_data;
    logic                  s2_valid;
    decode_pkt_t           s2_data;

    logic                  fwd_s2_valid;
    logic [REG_ADDR_W-1:0] fwd_s2_rd;
    logic [XL:0]           fwd_s2_wdata;
    logic                  fwd_s2_csr;

    exec_pkt_t             s2_out_data;        // Execute result into s3
    logic                  s3_valid;
    exec_pkt_t             s3_data;

    logic [XL:0]           wb_wdata;           // Final writeback value
    logic                  csr_en;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XL:0]           csr_wdata;
    logic [XL:0]           csr_rdata;
    logic                  gpr_wen;
    logic [REG_ADDR_W-1:0] gpr_rd;
    logic [XL:0]           gpr_wdata;

    // --------------------
    // Writeback
    assign csr_en    = s3_valid && s3_data.is_csr;
    assign csr_addr  = s3_data.csr_addr;
    assign csr_wdata = s3_data.result;         // rs1 value for CSRRW
    assign wb_wdata  = s3_data.is_csr ? csr_rdata : s3_data.result;

    assign gpr_wen   = s3_valid && (s3_data.rd != '0); // No write for x0
    assign gpr_rd    = s3_data.rd;
    assign gpr_wdata = wb_wdata;

    assign instr_busy = s1_bubble;
    assign trs_valid  = s3_valid;              // Writeback always retires
    assign trs_instr  = s3_data.instr;
    assign trs_rd     = s3_data.rd;
    assign trs_wdata  = wb_wdata;
    assign instr_ret  = trs_valid;

    // --------------------
    // Stages
    frv_gprs i_gprs (
        .g_clk     (g_clk       ),
        .rst       (rst         ),
        .rs1_addr  (s1_rs1_addr ),
        .rs2_addr  (s1_rs2_addr ),
        .rs1_rdata (s1_rs1_rdata),
        .rs2_rdata (s1_rs2_rdata),
        .rd_wen    (gpr_wen     ),
        .rd_addr   (gpr_rd      ),
        .rd_wdata  (gpr_wdata   )
    );

    frv_forward i_forward (
        .g_clk         (g_clk        ),
        .rst           (rst          ),
        .rs1_addr      (s1_rs1_addr  ),
        .rs2_addr      (s1_rs2_addr  ),
        .rs1_used      (s1_rs1_used  ),
        .rs2_used      (s1_rs2_used  ),
        .gpr_rs1_rdata (s1_rs1_rdata ),
        .gpr_rs2_rdata (s1_rs2_rdata ),
        .fwd_s2_valid  (fwd_s2_valid ),
        .fwd_s2_rd     (fwd_s2_rd    ),
        .fwd_s2_wdata  (fwd_s2_wdata ),
        .fwd_s2_csr    (fwd_s2_csr   ),
        .fwd_s3_valid  (s3_valid     ), // Writeback forwarding source
        .fwd_s3_rd     (s3_data.rd   ),
        .fwd_s3_wdata  (wb_wdata     ),
        .fwd_rs1_rdata (fwd_rs1_rdata),
        .fwd_rs2_rdata (fwd_rs2_rdata),
        .bubble        (s1_bubble    )
    );

    frv_decode i_decode (
        .instr_valid   (instr_valid  ),
        .instr_data    (instr_data   ),
        .bubble        (s1_bubble    ),
        .fwd_rs1_rdata (fwd_rs1_rdata),
        .fwd_rs2_rdata (fwd_rs2_rdata),
        .rs1_addr      (s1_rs1_addr  ),
        .rs2_addr      (s1_rs2_addr  ),
        .rs1_used      (s1_rs1_used  ),
        .rs2_used      (s1_rs2_used  ),
        .s2_valid      (s1_out_valid ),
        .s2_data       (s1_out_data  )
    );

    frv_stage_reg #(.payload_t(decode_pkt_t)) i_s2_reg (
        .g_clk     (g_clk       ),
        .rst       (rst         ),
        .in_valid  (s1_out_valid),
        .in_data   (s1_out_data ),
        .out_valid (s2_valid    ),
        .out_data  (s2_data     )
    );

    frv_execute i_execute (
        .s2_valid     (s2_valid    ),
        .s2_data      (s2_data     ),
        .s3_data      (s2_out_data ),
        .fwd_s2_valid (fwd_s2_valid),
        .fwd_s2_rd    (fwd_s2_rd   ),
        .fwd_s2_wdata (fwd_s2_wdata),
        .fwd_s2_csr   (fwd_s2_csr  )
    );

    frv_stage_reg #(.payload_t(exec_pkt_t)) i_s3_reg (
        .g_clk     (g_clk      ),
        .rst       (rst        ),
        .in_valid  (s2_valid   ), // No stall past decode
        .in_data   (s2_out_data),
        .out_valid (s3_valid   ),
        .out_data  (s3_data    )
    );

    frv_csrs i_csrs (
        .g_clk     (g_clk    ),
        .rst       (rst      ),
        .csr_en    (csr_en   ),
        .csr_addr  (csr_addr ),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .instr_ret (instr_ret)
    );

endmodule

// File: verif/tb_frv_pipeline.sv
// --------------------
// Testbench for the three-stage integer pipeline
// Random instructions checked against an architectural model
// --------------------
`timescale 1ns/1ps

module tb_frv_pipeline;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_RANDOM = 400;            // Random instructions after directed ones
    localparam int WAIT_LIMIT = 20;             // Cycles before a wait gives up
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_SYS = 7'b1110011;

    logic        g_clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr_data;
    logic        instr_busy;
    logic        trs_valid;
    logic [31:0] trs_instr;
    logic [4:0]  trs_rd;
    logic [31:0] trs_wdata;
    logic        instr_ret;

    logic [31:0] rng_state;                     // Xorshift state
    logic [31:0] model_regs [0:31];             // Architectural GPRs
    logic [31:0] model_mscratch;
    int          n_accepted;                    // Also the model minstret
    int          n_retired;
    int          busy_hits;                     // Stall cycles observed
    int          val_errs;
    int          other_errs;
    logic        timed_out;
    logic [4:0]  exp_rd_q [$];                  // Expected trace in program order
    logic [31:0] exp_wdata_q [$];
    logic [31:0] exp_instr_q [$];

    frv_pipeline uut (
        .g_clk       (g_clk      ),
        .rst         (rst        ),
        .instr_valid (instr_valid),
        .instr_data  (instr_data ),
        .instr_busy  (instr_busy ),
        .trs_valid   (trs_valid  ),
        .trs_instr   (trs_instr  ),
        .trs_rd      (trs_rd     ),
        .trs_wdata   (trs_wdata  ),
        .instr_ret   (instr_ret  )
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD/2) g_clk = ~g_clk;
    end

    // --------------------
    // Stimulus helpers
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[3:0] < 4'd12) ? {3'b000, r[5:4]} : r[9:5]; // Mostly x0..x3
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};         // Also CSRRW with the CSR as imm
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = next_rand();
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        case (r % 32'd9)
            32'd0:   return encode_rtype(7'h00, 3'b000, rd, rs1, rs2);     // ADD
            32'd1:   return encode_rtype(7'h20, 3'b000, rd, rs1, rs2);     // SUB
            32'd2:   return encode_rtype(7'h00, 3'b111, rd, rs1, rs2);     // AND
            32'd3:   return encode_rtype(7'h00, 3'b110, rd, rs1, rs2);     // OR
            32'd4:   return encode_rtype(7'h00, 3'b100, rd, rs1, rs2);     // XOR
            32'd5:   return encode_rtype(7'h00, 3'b010, rd, rs1, rs2);     // SLT
            32'd6:   return encode_itype(r[31:20], rs1, 3'b000, rd, OPC_IMM);
            32'd7:   return encode_itype(12'h340, rs1, 3'b001, rd, OPC_SYS);
            default: return encode_itype(12'hB02, rs1, 3'b001, rd, OPC_SYS);
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERR %s got 0x%08h exp 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // --------------------
    // Architectural model applied one instruction at a time in program order
    task automatic apply_to_model(input logic [31:0] instr);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        rd  = instr[11:7];
        a   = model_regs[instr[19:15]];
        b   = (instr[6:0] == 7'b0110011) ? model_regs[instr[24:20]]
                                         : {{20{instr[31]}}, instr[31:20]};
        res = 32'd0;
        if (instr[6:0] == OPC_SYS) begin
            if (instr[31:20] == 12'h340) begin
                res = model_mscratch;           // Old value out and rs1 in
                model_mscratch = a;
            end else begin
                res = n_accepted;               // Everything before it has retired
            end
        end else if (instr[6:0] == OPC_IMM) begin
            res = a + b;
        end else begin
            case ({instr[31:25], instr[14:12]})
                {7'h20, 3'b000}: res = a - b;
                {7'h00, 3'b111}: res = a & b;
                {7'h00, 3'b110}: res = a | b;
                {7'h00, 3'b100}: res = a ^ b;
                {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:         res = a + b;
            endcase
        end
        if (rd != 5'd0) begin
            model_regs[rd] = res;               // x0 stays zero
        end
        exp_rd_q.push_back(rd);
        exp_wdata_q.push_back(res);
        exp_instr_q.push_back(instr);
        n_accepted++;
    endtask

    // Offer one word and hold it while the DUT stalls
    task automatic issue(input logic [31:0] instr);
        int waits;
        waits = 0;
        if (!timed_out) begin
            @(negedge g_clk);
            instr_valid = 1'b1;
            instr_data  = instr;
            #(CLK_PERIOD/4);                    // Busy settled before the edge
            while (instr_busy && waits < WAIT_LIMIT) begin
                busy_hits++;
                @(negedge g_clk);
                #(CLK_PERIOD/4);
                waits++;
            end
            if (instr_busy) begin
                timed_out = 1'b1;
                other_errs++;
                $display("Instruction %08h was never accepted, busy stuck high", instr);
            end else begin
                apply_to_model(instr);          // Taken at the coming edge
            end
        end
    endtask

    task automatic idle_cycle();
        if (!timed_out) begin
            @(negedge g_clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waits;
        waits = 0;
        @(negedge g_clk);
        instr_valid = 1'b0;
        #(CLK_PERIOD/4);
        while (exp_rd_q.size() != 0 && waits < WAIT_LIMIT) begin
            @(negedge g_clk);
            #(CLK_PERIOD/4);
            waits++;
        end
        if (exp_rd_q.size() != 0) begin
            other_errs++;
            $display("Pipeline did not drain, %0d instructions never retired", exp_rd_q.size());
        end
    endtask

    // --------------------
    // Trace monitor sampling at the falling edge
    always @(negedge g_clk) begin
        if (!rst && trs_valid) begin
            n_retired++;
            check("instr_ret", {31'd0, instr_ret}, 32'd1);
            if (exp_rd_q.size() == 0) begin
                other_errs++;
                $display("Retirement seen with no instruction outstanding");
            end else begin
                check("trs_rd", {27'd0, trs_rd}, {27'd0, exp_rd_q.pop_front()});
                check("trs_wdata", trs_wdata, exp_wdata_q.pop_front());
                check("trs_instr", trs_instr, exp_instr_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] imm;
        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr_data     = 32'd0;
        rng_state      = 32'd90;
        model_mscratch = 32'd0;
        n_accepted     = 0;
        n_retired      = 0;
        busy_hits      = 0;
        val_errs       = 0;
        other_errs     = 0;
        timed_out      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (2) @(posedge g_clk);            // Two reset cycles
        @(negedge g_clk);
        rst         = 1'b0;
        instr_valid = 1'b1;                     // Reads x1 while the pipeline is empty
        instr_data  = encode_rtype(7'h00, 3'b111, 5'd0, 5'd1, 5'd0);
        #(CLK_PERIOD/4);
        check("trs_valid", {31'd0, trs_valid}, 32'd0);
        check("instr_busy", {31'd0, instr_busy}, 32'd0);
        apply_to_model(instr_data);

        // Known value in every GPR first
        for (int r = 1; r < 32; r++) begin
            imm = next_rand();
            issue(encode_itype(imm[11:0], 5'd0, 3'b000, r[4:0], OPC_IMM));
        end

        // --------------------
        // Directed corner cases
        issue(encode_itype(12'h340, 5'd2, 3'b001, 5'd1, OPC_SYS)); // CSRRW x1, mscratch, x2
        issue(encode_rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd1));      // Needs the CSR result
        issue(encode_itype(12'hB02, 5'd4, 3'b001, 5'd5, OPC_SYS)); // minstret write dropped
        issue(encode_itype(12'hB02, 5'd0, 3'b001, 5'd6, OPC_SYS));
        issue(encode_rtype(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));      // Result to x0
        issue(encode_rtype(7'h00, 3'b000, 5'd7, 5'd0, 5'd0));      // x0 still reads zero
        issue(encode_itype(12'hFFB, 5'd0, 3'b000, 5'd8, OPC_IMM)); // ADDI -5

        for (int i = 0; i < NUM_RANDOM; i++) begin
            imm = next_rand();
            if (imm[2:0] == 3'd0) begin
                idle_cycle();                   // Occasional gap in the stream
            end
            issue(random_instr());
        end

        if (!timed_out) begin
            drain();
            repeat (3) @(negedge g_clk);        // Nothing extra may retire
            check("retire_count", n_retired, n_accepted);
            if (busy_hits == 0) begin
                other_errs++;
                $display("instr_busy never went high on a CSR dependency");
            end
        end

        $display("Done: %0d accepted, %0d retired, %0d value errors, %0d other errors",
                 n_accepted, n_retired, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/frv_pkg.sv
design/frv_gprs.sv
design/frv_stage_reg.sv
design/frv_forward.sv
design/frv_decode.sv
design/frv_execute.sv
design/frv_csrs.sv
design/frv_pipeline.sv
verif/tb_frv_pipeline.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_frv_pipeline -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
